// File: logic/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// datapath and register file sizes
`define MIPS_XLEN        32
`define MIPS_REG_ADDR_W  5
`define MIPS_NUM_REGS    32

// instruction field widths
`define MIPS_OPCODE_W    6
`define MIPS_FUNC_W      6
`define MIPS_IMM_W       16
`define MIPS_SHAMT_W     5

// branch immediate counts words, offset is in bytes
`define MIPS_BRANCH_SHIFT 2

`endif

// File: logic/mips_pkg.sv
`default_nettype none

`include "mips_macros.svh"

package mips_pkg;

    // primary opcodes, 0 selects the func field
    typedef enum logic [`MIPS_OPCODE_W-1:0] {
        op_rtype = 6'b000000,
        op_beq   = 6'b000100,
        op_bne   = 6'b000101,
        op_blez  = 6'b000110,
        op_bgtz  = 6'b000111,
        op_addi  = 6'b001000,
        op_addiu = 6'b001001,
        op_slti  = 6'b001010,
        op_andi  = 6'b001100,
        op_ori   = 6'b001101,
        op_xori  = 6'b001110,
        op_lui   = 6'b001111
    } opcode_e;

    // r-type func codes
    typedef enum logic [`MIPS_FUNC_W-1:0] {
        func_sll     = 6'b000000,
        func_srl     = 6'b000010,
        func_sra     = 6'b000011,
        func_sllv    = 6'b000100,
        func_srlv    = 6'b000110,
        func_syscall = 6'b001100,
        func_add     = 6'b100000,
        func_addu    = 6'b100001,
        func_sub     = 6'b100010,
        func_subu    = 6'b100011,
        func_and     = 6'b100100,
        func_or      = 6'b100101,
        func_xor     = 6'b100110,
        func_nor     = 6'b100111,
        func_slt     = 6'b101010
    } func_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_lui_pass
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lez,
        br_gtz
    } branch_cond_e;

    // decoded control for one instruction
    typedef struct packed {
        alu_op_e                     alu_op;
        logic                        use_imm;
        logic                        imm_signed;
        logic                        use_shamt;
        logic [`MIPS_SHAMT_W-1:0]    shamt;
        logic [`MIPS_IMM_W-1:0]      imm;
        logic [`MIPS_REG_ADDR_W-1:0] rs_num;
        logic [`MIPS_REG_ADDR_W-1:0] rt_num;
        logic [`MIPS_REG_ADDR_W-1:0] dest_num;
        logic                        reg_we;
        branch_cond_e                branch_cond;
        logic                        halt;
    } ctrl_t;

    // 1 + 5 + 32 bits
    typedef struct packed {
        logic                        wb_en;
        logic [`MIPS_REG_ADDR_W-1:0] wb_num;
        logic [`MIPS_XLEN-1:0]       wb_data;
    } wb_t;

    // 1 + 32 bits
    typedef struct packed {
        logic                  taken;
        logic [`MIPS_XLEN-1:0] offset;
    } branch_t;

    // sign extend a 16 bit immediate to the data width
    function automatic logic [`MIPS_XLEN-1:0] sext_imm(input logic [`MIPS_IMM_W-1:0] imm);
        return {{(`MIPS_XLEN-`MIPS_IMM_W){imm[`MIPS_IMM_W-1]}}, imm};
    endfunction

endpackage

`default_nettype wire

// File: logic/instr_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_macros.svh"

module instr_decode (
    input  wire logic [`MIPS_XLEN-1:0] instr,
    output mips_pkg::ctrl_t            ctrl
);

    mips_pkg::opcode_e           opcode;
    mips_pkg::func_e             func;
    logic [`MIPS_REG_ADDR_W-1:0] rd_num;
    logic [`MIPS_REG_ADDR_W-1:0] dest;
    logic                        we;

    // fixed field positions of the mips encoding
    assign opcode = mips_pkg::opcode_e'(instr[31:26]);
    assign func   = mips_pkg::func_e'(instr[5:0]);
    assign rd_num = instr[15:11];

    always_comb begin
        ctrl             = '0;
        ctrl.rs_num      = instr[25:21];
        ctrl.rt_num      = instr[20:16];
        ctrl.shamt       = instr[10:6];
        ctrl.imm         = instr[15:0];
        ctrl.alu_op      = mips_pkg::alu_add;
        ctrl.branch_cond = mips_pkg::br_none;
        // i-type targets rt unless told otherwise
        dest = instr[20:16];
        we   = 1'b0;

        case (opcode)
            mips_pkg::op_rtype: begin
                dest = rd_num;
                we   = 1'b1;
                case (func)
                    mips_pkg::func_add,
                    mips_pkg::func_addu: ctrl.alu_op = mips_pkg::alu_add;
                    mips_pkg::func_sub,
                    mips_pkg::func_subu: ctrl.alu_op = mips_pkg::alu_sub;
                    mips_pkg::func_and:  ctrl.alu_op = mips_pkg::alu_and;
                    mips_pkg::func_or:   ctrl.alu_op = mips_pkg::alu_or;
                    mips_pkg::func_xor:  ctrl.alu_op = mips_pkg::alu_xor;
                    mips_pkg::func_nor:  ctrl.alu_op = mips_pkg::alu_nor;
                    mips_pkg::func_slt:  ctrl.alu_op = mips_pkg::alu_slt;
                    mips_pkg::func_sll: begin
                        ctrl.alu_op    = mips_pkg::alu_sll;
                        ctrl.use_shamt = 1'b1;
                    end
                    mips_pkg::func_srl: begin
                        ctrl.alu_op    = mips_pkg::alu_srl;
                        ctrl.use_shamt = 1'b1;
                    end
                    mips_pkg::func_sra: begin
                        ctrl.alu_op    = mips_pkg::alu_sra;
                        ctrl.use_shamt = 1'b1;
                    end
                    // variable shifts take the amount from rs
                    mips_pkg::func_sllv: ctrl.alu_op = mips_pkg::alu_sll;
                    mips_pkg::func_srlv: ctrl.alu_op = mips_pkg::alu_srl;
                    // syscall and unknown func stop the core
                    default: begin
                        we        = 1'b0;
                        ctrl.halt = 1'b1;
                    end
                endcase
            end
            mips_pkg::op_addi,
            mips_pkg::op_addiu: begin
                ctrl.use_imm    = 1'b1;
                ctrl.imm_signed = 1'b1;
                we              = 1'b1;
            end
            mips_pkg::op_slti: begin
                ctrl.alu_op     = mips_pkg::alu_slt;
                ctrl.use_imm    = 1'b1;
                ctrl.imm_signed = 1'b1;
                we              = 1'b1;
            end
            // logical immediates are zero extended
            mips_pkg::op_andi: begin
                ctrl.alu_op  = mips_pkg::alu_and;
                ctrl.use_imm = 1'b1;
                we           = 1'b1;
            end
            mips_pkg::op_ori: begin
                ctrl.alu_op  = mips_pkg::alu_or;
                ctrl.use_imm = 1'b1;
                we           = 1'b1;
            end
            mips_pkg::op_xori: begin
                ctrl.alu_op  = mips_pkg::alu_xor;
                ctrl.use_imm = 1'b1;
                we           = 1'b1;
            end
            mips_pkg::op_lui: begin
                ctrl.alu_op = mips_pkg::alu_lui_pass;
                we          = 1'b1;
            end
            // branches never write a register
            mips_pkg::op_beq:  ctrl.branch_cond = mips_pkg::br_eq;
            mips_pkg::op_bne:  ctrl.branch_cond = mips_pkg::br_ne;
            mips_pkg::op_blez: ctrl.branch_cond = mips_pkg::br_lez;
            mips_pkg::op_bgtz: ctrl.branch_cond = mips_pkg::br_gtz;
            default: ctrl.halt = 1'b1;
        endcase

        ctrl.dest_num = dest;
        // $zero is never a real destination
        ctrl.reg_we   = we && (dest != '0);
    end

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_macros.svh"

module alu (
    input  mips_pkg::ctrl_t             ctrl,
    input  wire logic [`MIPS_XLEN-1:0]  rs_data,
    input  wire logic [`MIPS_XLEN-1:0]  rt_data,
    output logic      [`MIPS_XLEN-1:0]  result
);

    logic [`MIPS_XLEN-1:0]    ext_imm;
    logic [`MIPS_XLEN-1:0]    op_b;
    logic [`MIPS_SHAMT_W-1:0] sh_amt;
    logic                     less;

    // immediate extension picked by decode
    assign ext_imm = ctrl.imm_signed ? mips_pkg::sext_imm(ctrl.imm)
                                     : {{(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}, ctrl.imm};
    assign op_b    = ctrl.use_imm ? ext_imm : rt_data;

    // shamt field or low bits of rs for the v forms
    assign sh_amt = ctrl.use_shamt ? ctrl.shamt : rs_data[`MIPS_SHAMT_W-1:0];

    // signed compare for slt and slti
    assign less = $signed(rs_data) < $signed(op_b);

    always_comb begin
        case (ctrl.alu_op)
            mips_pkg::alu_add: result = rs_data + op_b;
            mips_pkg::alu_sub: result = rs_data - op_b;
            mips_pkg::alu_and: result = rs_data & op_b;
            mips_pkg::alu_or:  result = rs_data | op_b;
            mips_pkg::alu_xor: result = rs_data ^ op_b;
            mips_pkg::alu_nor: result = ~(rs_data | op_b);
            // shifts always move rt
            mips_pkg::alu_sll: result = rt_data << sh_amt;
            mips_pkg::alu_srl: result = rt_data >> sh_amt;
            mips_pkg::alu_sra: result = $unsigned($signed(rt_data) >>> sh_amt);
            mips_pkg::alu_slt: result = {{(`MIPS_XLEN-1){1'b0}}, less};
            // lui puts imm in the upper half
            mips_pkg::alu_lui_pass: result = {ctrl.imm, {(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_macros.svh"

module reg_file (
    input  wire logic                        clk,
    input  wire logic                        rst_b,
    input  wire logic [`MIPS_REG_ADDR_W-1:0] rs_num,
    input  wire logic [`MIPS_REG_ADDR_W-1:0] rt_num,
    output logic      [`MIPS_XLEN-1:0]       rs_data,
    output logic      [`MIPS_XLEN-1:0]       rt_data,
    input  mips_pkg::wb_t                    wb
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

    // write port fed from the retired record
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wb_en && (wb.wb_num != '0)) begin
            regs[wb.wb_num] <= wb.wb_data;
        end
    end

    // $zero first, then pending write, then array
    assign rs_data = (rs_num == '0) ? '0 :
                     (wb.wb_en && (wb.wb_num == rs_num)) ? wb.wb_data : regs[rs_num];
    assign rt_data = (rt_num == '0) ? '0 :
                     (wb.wb_en && (wb.wb_num == rt_num)) ? wb.wb_data : regs[rt_num];

endmodule

`default_nettype wire

// File: logic/branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_macros.svh"

module branch_unit (
    input  mips_pkg::ctrl_t            ctrl,
    input  wire logic [`MIPS_XLEN-1:0] rs_data,
    input  wire logic [`MIPS_XLEN-1:0] rt_data,
    output mips_pkg::branch_t          branch
);

    logic taken;
    logic rs_zero;
    logic rs_neg;

    assign rs_zero = (rs_data == '0);
    assign rs_neg  = rs_data[`MIPS_XLEN-1];

    always_comb begin
        case (ctrl.branch_cond)
            mips_pkg::br_eq:  taken = (rs_data == rt_data);
            mips_pkg::br_ne:  taken = (rs_data != rt_data);
            // signed compares against zero
            mips_pkg::br_lez: taken = rs_neg || rs_zero;
            mips_pkg::br_gtz: taken = !rs_neg && !rs_zero;
            default:          taken = 1'b0;
        endcase
    end

    // word offset to bytes, zero when not taken
    assign branch.taken  = taken;
    assign branch.offset = taken ? (mips_pkg::sext_imm(ctrl.imm) << `MIPS_BRANCH_SHIFT)
                                 : '0;

endmodule

`default_nettype wire

// File: logic/retire_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_macros.svh"

module retire_stage (
    input  wire logic                  clk,
    input  wire logic                  rst_b,
    input  mips_pkg::ctrl_t            ctrl,
    input  wire logic [`MIPS_XLEN-1:0] alu_result,
    input  mips_pkg::branch_t          branch_next,
    output mips_pkg::wb_t              wb,
    output mips_pkg::branch_t          branch,
    output logic                       halted
);

    mips_pkg::wb_t     wb_next;
    mips_pkg::branch_t branch_gated;

    // nothing retires once the core has stopped
    always_comb begin
        wb_next.wb_en   = ctrl.reg_we && !halted;
        wb_next.wb_num  = ctrl.dest_num;
        wb_next.wb_data = alu_result;

        branch_gated.taken  = branch_next.taken && !halted;
        branch_gated.offset = halted ? {`MIPS_XLEN{1'b0}} : branch_next.offset;
    end

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            wb     <= '0;
            branch <= '0;
            halted <= 1'b0;
        end else begin
            wb     <= wb_next;
            branch <= branch_gated;
            // sticky until reset
            if (ctrl.halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_macros.svh"

module exec_top (
    input  wire logic                  clk,
    input  wire logic                  rst_b,
    input  wire logic [`MIPS_XLEN-1:0] instr,
    output mips_pkg::wb_t              wb,
    output mips_pkg::branch_t          branch,
    output logic                       halted
);

    mips_pkg::ctrl_t       ctrl;
    mips_pkg::branch_t     branch_next;
    logic [`MIPS_XLEN-1:0] rs_data;
    logic [`MIPS_XLEN-1:0] rt_data;
    logic [`MIPS_XLEN-1:0] alu_result;

    instr_decode decode_i (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // write port is driven by the registered wb output
    reg_file reg_file_i (
        .clk     (clk),
        .rst_b   (rst_b),
        .rs_num  (ctrl.rs_num),
        .rt_num  (ctrl.rt_num),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (wb)
    );

    alu alu_i (
        .ctrl    (ctrl),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .result  (alu_result)
    );

    branch_unit branch_i (
        .ctrl    (ctrl),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .branch  (branch_next)
    );

    // single register stage, 1 cycle latency
    retire_stage retire_i (
        .clk         (clk),
        .rst_b       (rst_b),
        .ctrl        (ctrl),
        .alu_result  (alu_result),
        .branch_next (branch_next),
        .wb          (wb),
        .branch      (branch),
        .halted      (halted)
    );

endmodule

`default_nettype wire

// File: testbench/exec_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_macros.svh"

module exec_tb;

    localparam int    RESET_CYCLES    = 10;
    localparam int    MAX_LINES       = 256;
    localparam int    WATCHDOG_CYCLES = 2000;
    localparam string PATTERN_FILE    = "testbench/exec_patterns.txt";

    logic                  clk;
    logic                  rst_b;
    logic [`MIPS_XLEN-1:0] instr;
    mips_pkg::wb_t         wb;
    mips_pkg::branch_t     branch;
    logic                  halted;

    exec_top dut_i (
        .clk    (clk),
        .rst_b  (rst_b),
        .instr  (instr),
        .wb     (wb),
        .branch (branch),
        .halted (halted)
    );

    // 10 ns period
    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    // print the reason, then the verdict, then stop
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_wb(input string name, input mips_pkg::wb_t exp,
                            input mips_pkg::wb_t act);
        logic bad;
        bad = (act.wb_en !== exp.wb_en);
        // register number and data only matter for an enabled write
        if (exp.wb_en && ((act.wb_num !== exp.wb_num) || (act.wb_data !== exp.wb_data))) begin
            bad = 1'b1;
        end
        if (bad) begin
            stop_on_error($sformatf(
                "Mismatch %s wb expected en=%0b num=%0d data=%h actual en=%0b num=%0d data=%h",
                name, exp.wb_en, exp.wb_num, exp.wb_data,
                act.wb_en, act.wb_num, act.wb_data));
        end
    endtask

    task automatic check_branch(input string name, input mips_pkg::branch_t exp,
                                input mips_pkg::branch_t act);
        if (act !== exp) begin
            stop_on_error($sformatf(
                "Mismatch %s branch expected taken=%0b offset=%h actual taken=%0b offset=%h",
                name, exp.taken, exp.offset, act.taken, act.offset));
        end
    endtask

    task automatic check_halted(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch %s halted expected %0b actual %0b",
                                    name, exp, act));
        end
    endtask

    // hard stop if the main sequence ever stalls
    initial begin : watchdog
        for (int c = 0; c < WATCHDOG_CYCLES; c++) begin
            @(posedge clk);
        end
        stop_on_error("timeout, the run did not finish within the cycle limit");
    end

    initial begin : main_seq
        int                fd;
        int                n_fields;
        int                n_lines;
        int                n_checked;
        string             line;
        string             name;
        logic [31:0]       v_instr;
        logic [31:0]       v_en;
        logic [31:0]       v_num;
        logic [31:0]       v_data;
        logic [31:0]       v_taken;
        logic [31:0]       v_offset;
        logic [31:0]       v_halted;
        mips_pkg::wb_t     exp_wb;
        mips_pkg::branch_t exp_branch;

        rst_b     = 1'b0;
        // all-zero word is sll $0 and writes nothing
        instr     = '0;
        n_lines   = 0;
        n_checked = 0;

        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            stop_on_error({"could not open the pattern file ", PATTERN_FILE});
        end

        // hold reset, bounded cycle count
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
        end
        rst_b = 1'b1;

        // outputs still show the reset state here
        check_wb("reset", '0, wb);
        check_branch("reset", '0, branch);
        check_halted("reset", 1'b0, halted);

        while (!$feof(fd) && (n_lines < MAX_LINES)) begin
            line = "";
            void'($fgets(line, fd));
            n_lines++;
            // skip blank and comment lines
            if ((line.len() < 2) || (line.getc(0) == "#")) begin
                continue;
            end
            n_fields = $sscanf(line, "%s %h %h %h %h %h %h %h", name, v_instr,
                               v_en, v_num, v_data, v_taken, v_offset, v_halted);
            if (n_fields != 8) begin
                stop_on_error($sformatf("pattern line %0d does not have 8 fields", n_lines));
            end

            exp_wb.wb_en      = v_en[0];
            exp_wb.wb_num     = v_num[`MIPS_REG_ADDR_W-1:0];
            exp_wb.wb_data    = v_data;
            exp_branch.taken  = v_taken[0];
            exp_branch.offset = v_offset;

            // driven on the falling edge, executed on the next rising edge
            instr = v_instr;
            @(posedge clk);
            // one cycle of latency, sample mid-cycle
            @(negedge clk);
            check_wb(name, exp_wb, wb);
            check_branch(name, exp_branch, branch);
            check_halted(name, v_halted[0], halted);
            n_checked++;
        end

        if (!$feof(fd)) begin
            stop_on_error("pattern file is longer than the line limit");
        end
        $fclose(fd);

        if (n_checked > 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_on_error("no pattern lines were found in the pattern file");
        end
    end

endmodule

`default_nettype wire

// File: testbench/exec_patterns.txt
# name instr wb_en wb_num wb_data taken offset halted
# all values hex, one instruction per line, results seen one cycle later
rst_read       00A60821 1 01 00000000 0 00000000 0
lui_hi         3C021234 1 02 12340000 0 00000000 0
ori_lo_dep     34425678 1 02 12345678 0 00000000 0
addi_neg       2003FFFB 1 03 FFFFFFFB 0 00000000 0
add            00432020 1 04 12345673 0 00000000 0
sub            00432822 1 05 1234567D 0 00000000 0
and            00433024 1 06 12345678 0 00000000 0
or             00433825 1 07 FFFFFFFB 0 00000000 0
xor            00434026 1 08 EDCBA983 0 00000000 0
nor            00434827 1 09 00000004 0 00000000 0
slt_true       0062502A 1 0A 00000001 0 00000000 0
slt_false      0043582A 1 0B 00000000 0 00000000 0
sll_shamt      00036100 1 0C FFFFFFB0 0 00000000 0
srl_shamt      00036902 1 0D 0FFFFFFF 0 00000000 0
sra_shamt      00037103 1 0E FFFFFFFF 0 00000000 0
addi_amount    200F0008 1 0F 00000008 0 00000000 0
sllv_dep       01E38004 1 10 FFFFFB00 0 00000000 0
srlv           01E38806 1 11 00FFFFFF 0 00000000 0
write_r0       20400001 0 00 00000000 0 00000000 0
read_r0        00009021 1 12 00000000 0 00000000 0
andi_zext      30738F0F 1 13 00008F0B 0 00000000 0
ori_zext       34148001 1 14 00008001 0 00000000 0
xori_zext      3875FFFF 1 15 FFFF0004 0 00000000 0
addiu_sext     24568000 1 16 1233D678 0 00000000 0
slti_min       28778000 1 17 00000000 0 00000000 0
slti_neg1      2878FFFF 1 18 00000001 0 00000000 0
beq_taken      10460003 0 00 00000000 1 0000000C 0
beq_not        10430003 0 00 00000000 0 00000000 0
bne_taken_back 1443FFFE 0 00 00000000 1 FFFFFFF8 0
bne_not        14460005 0 00 00000000 0 00000000 0
blez_neg       18600010 0 00 00000000 1 00000040 0
blez_zero      1820FFFF 0 00 00000000 1 FFFFFFFC 0
blez_pos       18400007 0 00 00000000 0 00000000 0
bgtz_pos       1C407FFF 0 00 00000000 1 0001FFFC 0
bgtz_neg       1C600001 0 00 00000000 0 00000000 0
bgtz_zero      1C200001 0 00 00000000 0 00000000 0
bad_opcode     FC000000 0 00 00000000 0 00000000 1
add_halted     0043C820 0 00 00000000 0 00000000 1
beq_halted     10460003 0 00 00000000 0 00000000 1
addi_halted    201A0001 0 00 00000000 0 00000000 1

// File: sim.f
+incdir+logic
logic/mips_pkg.sv
logic/instr_decode.sv
logic/alu.sv
logic/reg_file.sv
logic/branch_unit.sv
logic/retire_stage.sv
logic/exec_top.sv
testbench/exec_tb.sv

// File: Bender.yml
package:
  name: mips_exec

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mips_pkg.sv
      - logic/instr_decode.sv
      - logic/alu.sv
      - logic/reg_file.sv
      - logic/branch_unit.sv
      - logic/retire_stage.sv
      - logic/exec_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/exec_tb.sv
